// File: tb/pfpu32_input.txt
// op opa opb result flag fpcsr, hex, one vector per line
// op 0 add, 1 sub, 4 eq, 5 lt, 6 le; result unused for compares, flag unused for add/sub
// fpcsr bits inv/ovf/inx; a line with op ff ends the list
0 3f800000 40000000 40400000 0 0
1 3f800000 40000000 bf800000 0 0
4 3f800000 3f800000 00000000 1 0
0 40400000 c0400000 00000000 0 0
5 3f800000 40000000 00000000 1 0
1 40400000 40400000 00000000 0 0
0 00000000 80000000 00000000 0 0
0 80000000 80000000 80000000 0 0
4 00000000 80000000 00000000 1 0
0 3f800000 33800000 3f800000 0 1
0 3f800001 33800000 3f800002 0 1
0 3f800000 33000000 3f800000 0 1
0 3f800000 33c00000 3f800001 0 1
1 3f800000 33000000 3f800000 0 1
0 3fc00000 3e800000 3fe00000 0 0
0 3fc00000 3fc00000 40400000 0 0
1 3f800000 3f400000 3e800000 0 0
4 3f800000 40000000 00000000 0 0
5 c0000000 bf800000 00000000 1 0
5 80000000 00000000 00000000 0 0
6 80000000 00000000 00000000 1 0
6 bf800000 3f800000 00000000 1 0
6 40000000 3f800000 00000000 0 0
0 7f7fffff 7f7fffff 7f800000 0 3
0 ff7fffff ff7fffff ff800000 0 3
1 7f800000 7f800000 7fc00000 0 4
0 7f800000 ff800000 7fc00000 0 4
0 7f800000 3f800000 7f800000 0 0
1 3f800000 7f800000 ff800000 0 0
5 3f800000 7fc00000 00000000 0 4
4 7fc00000 7fc00000 00000000 0 0
4 7f800001 3f800000 00000000 0 4
0 7fc12345 3f800000 7fc00000 0 0
0 7f800001 3f800000 7fc00000 0 4
6 ff800000 7f800000 00000000 1 0
0 00400000 3f800000 3f800000 0 0
4 00000001 00000000 00000000 1 0
1 00800001 00800000 00000000 0 1
ff 0 0 0 0 0

// File: all.f
logic/pfpu_pkg.sv
logic/pfpu_align_if.sv
logic/fp_operand_unpack.sv
logic/pfpu_fcmp.sv
logic/pfpu_addsub.sv
logic/pfpu_rnd.sv
logic/pfpu32_top.sv
tb/pfpu32_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= pfpu32_tb
FILELIST  ?= all.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/pfpu32_tb.sv
module pfpu32_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_VEC = 64;    // room in the vector memory
  localparam int VEC_W   = 6;     // words per vector

  logic        clk = 1'b0;
  logic        rst;
  logic        flush_i;
  logic        start_i;
  logic [2:0]  op_i;
  logic [31:0] opa_i;
  logic [31:0] opb_i;
  logic        take_i;
  logic        ready_o;
  logic [31:0] result_o;
  logic        arith_valid_o;
  logic        cmp_flag_o;
  logic        cmp_valid_o;
  logic [2:0]  fpcsr_o;

  logic [31:0] vec_mem [0:VEC_W*MAX_VEC-1];  // op, opa, opb, result, flag, fpcsr
  int          exp_q[$];                     // vector index per accepted op
  int          n_vec;
  int          cur_idx;
  bit          track_en;                     // accepted ops go into the queue
  bit          rand_take;
  int          err_cnt;
  int          check_cnt;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] last_result;                  // expected result of the latest add/sub
  bit          stall_prev;
  logic [31:0] held_result;
  logic [2:0]  held_fpcsr;
  logic        held_flag;
  logic        held_av;
  logic        held_cv;

  pfpu32_top UUT (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .start_i       (start_i),
    .op_i          (op_i),
    .opa_i         (opa_i),
    .opb_i         (opb_i),
    .take_i        (take_i),
    .ready_o       (ready_o),
    .result_o      (result_o),
    .arith_valid_o (arith_valid_o),
    .cmp_flag_o    (cmp_flag_o),
    .cmp_valid_o   (cmp_valid_o),
    .fpcsr_o       (fpcsr_o)
  );

  always #4 clk = ~clk;  // 8 ns period

  // consumer side, random stalls while streaming
  initial begin
    void'($urandom(67));  // fixed seed, same stall pattern every run
    forever begin
      @(posedge clk);
      #1;
      if (rand_take)
        take_i = ($urandom % 4) != 0;
      else
        take_i = 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // present one vector, hold it until accepted
  task automatic issue_vector(input int idx);
    cur_idx = idx;
    op_i    = vec_mem[VEC_W*idx][2:0];
    opa_i   = vec_mem[VEC_W*idx+1];
    opb_i   = vec_mem[VEC_W*idx+2];
    start_i = 1'b1;
    @(negedge clk);
    while (!ready_o) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitor, sampled mid cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    int   idx;
    logic ready_exp;
    if (!rst) begin
      // ready low only while a valid output waits for take
      ready_exp = !((arith_valid_o || cmp_valid_o) && !take_i);
      check_value("ready_o", 32'(ready_exp), 32'(ready_o));
      if (stall_prev) begin
        // output register must not move while stalled
        check_value("arith_valid_o (held)", 32'(held_av), 32'(arith_valid_o));
        check_value("cmp_valid_o (held)", 32'(held_cv), 32'(cmp_valid_o));
        check_value("result_o (held)", held_result, result_o);
        check_value("fpcsr_o (held)", 32'(held_fpcsr), 32'(fpcsr_o));
        check_value("cmp_flag_o (held)", 32'(held_flag), 32'(cmp_flag_o));
      end
      stall_prev  = (arith_valid_o | cmp_valid_o) & ~take_i;
      held_av     = arith_valid_o;
      held_cv     = cmp_valid_o;
      held_result = result_o;
      held_fpcsr  = fpcsr_o;
      held_flag   = cmp_flag_o;
      if (arith_valid_o && cmp_valid_o) begin
        err_cnt++;
        $display("both arith_valid_o and cmp_valid_o are high at %0t", $time);
      end
      if ((arith_valid_o || cmp_valid_o) && take_i) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("output at %0t with no operation outstanding", $time);
        end else begin
          idx = exp_q.pop_front();
          check_value("cmp_valid_o", 32'(vec_mem[VEC_W*idx][2]), 32'(cmp_valid_o));
          if (vec_mem[VEC_W*idx][2]) begin
            check_value("cmp_flag_o", vec_mem[VEC_W*idx+4], 32'(cmp_flag_o));
            check_value("result_o", last_result, result_o);  // untouched by compares
          end else begin
            check_value("result_o", vec_mem[VEC_W*idx+3], result_o);
            last_result = vec_mem[VEC_W*idx+3];
          end
          check_value("fpcsr_o", vec_mem[VEC_W*idx+5], 32'(fpcsr_o));
        end
      end
      if (start_i && ready_o && track_en)
        exp_q.push_back(cur_idx);  // taken on the coming edge
    end
  end

  // cycle limit scaled by vector count
  initial begin
    cycle_cnt = 0;
    @(posedge clk);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst         = 1'b1;
    flush_i     = 1'b0;
    start_i     = 1'b0;
    op_i        = 3'b000;
    opa_i       = '0;
    opb_i       = '0;
    take_i      = 1'b1;
    rand_take   = 1'b0;
    track_en    = 1'b0;
    cur_idx     = 0;
    err_cnt     = 0;
    check_cnt   = 0;
    last_result = '0;
    stall_prev  = 1'b0;
    $readmemh("tb/pfpu32_input.txt", vec_mem);
    n_vec = 0;
    while (n_vec < MAX_VEC && vec_mem[VEC_W*n_vec] != 32'hFF) n_vec++;
    cycle_limit = 40 * (n_vec + 3) + 100;

    repeat (10) @(posedge clk);
    #1 rst = 1'b0;
    @(negedge clk);
    check_value("arith_valid_o", 32'd0, 32'(arith_valid_o));
    check_value("cmp_valid_o", 32'd0, 32'(cmp_valid_o));
    check_value("fpcsr_o", 32'd0, 32'(fpcsr_o));
    @(posedge clk);
    #1;

    if (n_vec < 3) begin
      err_cnt++;
      $display("vector file holds %0d vectors, at least 3 needed", n_vec);
    end else begin
      // back to back stream, random back-pressure
      rand_take = 1'b1;
      track_en  = 1'b1;
      for (int i = 0; i < n_vec; i++) issue_vector(i);
      start_i = 1'b0;
      wait_drain();

      // flush with an add and a compare in flight
      rand_take = 1'b0;
      repeat (2) @(posedge clk);
      #1 track_en = 1'b0;
      issue_vector(0);
      issue_vector(2);
      start_i = 1'b0;
      flush_i = 1'b1;
      @(posedge clk);
      #1 flush_i = 1'b0;
      repeat (6) @(posedge clk);  // any output here is unexpected
      #1 track_en = 1'b1;
      issue_vector(1);
      start_i = 1'b0;
      wait_drain();
    end

    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// File: logic/pfpu32_top.sv
module pfpu32_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        flush_i,
  input  logic        start_i,
  input  logic [2:0]  op_i,
  input  logic [31:0] opa_i,
  input  logic [31:0] opb_i,
  input  logic        take_i,
  output logic        ready_o,
  output logic [31:0] result_o,
  output logic        arith_valid_o,
  output logic        cmp_flag_o,
  output logic        cmp_valid_o,
  output logic [2:0]  fpcsr_o
);

  pfpu_pkg::fpu_op_t   op;
  pfpu_pkg::fp_class_t cls_a;
  pfpu_pkg::fp_class_t cls_b;
  logic                adv;        // shared pipeline advance
  logic                cmp_valid;
  logic                cmp_flag;
  logic                cmp_inv;

  assign op      = pfpu_pkg::fpu_op_t'(op_i);
  assign ready_o = adv;            // accept only when the pipe moves

  pfpu_align_if u_align_if ();

  ////////////////////////////////////////////////////////////////////////////
  // operand analysis
  ////////////////////////////////////////////////////////////////////////////

  fp_operand_unpack u_unpack_a (.opa_i(opa_i), .class_o(cls_a));
  fp_operand_unpack u_unpack_b (.opa_i(opb_i), .class_o(cls_b));

  // compare and add/sub run side by side
  pfpu_fcmp u_fcmp (
    .clk         (clk),
    .rst         (rst),
    .flush_i     (flush_i),
    .adv_i       (adv),
    .start_i     (start_i),
    .op_i        (op),
    .a_i         (cls_a),
    .b_i         (cls_b),
    .cmp_valid_o (cmp_valid),
    .cmp_flag_o  (cmp_flag),
    .cmp_inv_o   (cmp_inv)
  );

  pfpu_addsub u_addsub (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush_i),
    .adv_i   (adv),
    .start_i (start_i),
    .op_i    (op),
    .a_i     (cls_a),
    .b_i     (cls_b),
    .align   (u_align_if.src)
  );

  // round, pack, flags
  pfpu_rnd u_rnd (
    .clk           (clk),
    .rst           (rst),
    .flush_i       (flush_i),
    .take_i        (take_i),
    .align         (u_align_if.dst),
    .cmp_valid_i   (cmp_valid),
    .cmp_flag_i    (cmp_flag),
    .cmp_inv_i     (cmp_inv),
    .adv_o         (adv),
    .result_o      (result_o),
    .arith_valid_o (arith_valid_o),
    .cmp_flag_o    (cmp_flag_o),
    .cmp_valid_o   (cmp_valid_o),
    .fpcsr_o       (fpcsr_o)
  );

endmodule

// File: logic/pfpu_rnd.sv
module pfpu_rnd (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush_i,
  input  logic                      take_i,
  pfpu_align_if.dst                 align,
  input  logic                      cmp_valid_i,
  input  logic                      cmp_flag_i,
  input  logic                      cmp_inv_i,
  output logic                      adv_o,
  output logic [pfpu_pkg::FP_W-1:0] result_o,
  output logic                      arith_valid_o,
  output logic                      cmp_flag_o,
  output logic                      cmp_valid_o,
  output logic [2:0]                fpcsr_o
);

  localparam int XW = pfpu_pkg::EXP_EXT_W;

  logic                        lsb;
  logic                        guard;
  logic                        rs;        // round or sticky
  logic                        round_up;
  logic                        inexact;
  logic [24:0]                 rounded;   // carry, hidden, 23 mantissa
  logic [pfpu_pkg::FRAC_W-1:0] mant;
  logic [XW-1:0]               exp_r;
  logic                        ovf;
  logic                        unf;
  logic [pfpu_pkg::FP_W-1:0]   res;
  logic [2:0]                  flags;
  logic [pfpu_pkg::FP_W-1:0]   inf_word;
  logic [pfpu_pkg::FP_W-1:0]   zero_word;

  // pipe moves when output is taken or empty
  assign adv_o = take_i | ~(arith_valid_o | cmp_valid_o);

  ////////////////////////////////////////////////////////////////////////////
  // round to nearest even
  ////////////////////////////////////////////////////////////////////////////

  assign lsb      = align.fract[3];
  assign guard    = align.fract[2];
  assign rs       = |align.fract[1:0];
  assign round_up = guard & (rs | lsb);  // tie goes to even
  assign inexact  = guard | rs;
  assign rounded  = {1'b0, align.fract[26:3]} + 25'(round_up);
  // rounding carry, renormalize by one
  assign mant     = rounded[24] ? rounded[23:1] : rounded[22:0];
  assign exp_r    = align.exp + XW'(rounded[24]);
  assign unf      = exp_r[XW-1] | (exp_r == '0);  // below normal range
  assign ovf      = ~exp_r[XW-1] & (exp_r >= XW'(255));

  assign inf_word  = {align.sign, {pfpu_pkg::EXP_W{1'b1}}, {pfpu_pkg::FRAC_W{1'b0}}};
  assign zero_word = {align.sign, {(pfpu_pkg::FP_W-1){1'b0}}};

  // special case select
  always_comb begin
    flags = 3'b000;
    if (align.nan | align.inv) begin
      res                      = pfpu_pkg::QNAN_CANON;
      flags[pfpu_pkg::FLAG_INV] = align.inv;
    end else if (align.inf) begin
      res = inf_word;                 // inf operand, exact
    end else if (align.zero) begin
      res = zero_word;
    end else if (ovf) begin
      res                       = inf_word;
      flags[pfpu_pkg::FLAG_OVF] = 1'b1;
      flags[pfpu_pkg::FLAG_INX] = 1'b1;
    end else if (unf) begin
      res                       = zero_word;  // flushed
      flags[pfpu_pkg::FLAG_INX] = 1'b1;
    end else begin
      res                       = {align.sign, exp_r[pfpu_pkg::EXP_W-1:0], mant};
      flags[pfpu_pkg::FLAG_INX] = inexact;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      arith_valid_o <= 1'b0;
      cmp_valid_o   <= 1'b0;
      cmp_flag_o    <= 1'b0;
      result_o      <= '0;
      fpcsr_o       <= 3'b000;
    end else if (flush_i) begin
      arith_valid_o <= 1'b0;
      cmp_valid_o   <= 1'b0;
    end else if (adv_o) begin
      arith_valid_o <= align.valid;
      cmp_valid_o   <= cmp_valid_i;
      if (align.valid) begin
        result_o <= res;
        fpcsr_o  <= flags;
      end else if (cmp_valid_i) begin
        cmp_flag_o <= cmp_flag_i;  // result_o left alone
        fpcsr_o    <= 3'b000;
        fpcsr_o[pfpu_pkg::FLAG_INV] <= cmp_inv_i;
      end
    end
  end

endmodule

// File: logic/pfpu_addsub.sv
module pfpu_addsub (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush_i,
  input  logic                adv_i,
  input  logic                start_i,
  input  pfpu_pkg::fpu_op_t   op_i,
  input  pfpu_pkg::fp_class_t a_i,
  input  pfpu_pkg::fp_class_t b_i,
  pfpu_align_if.src           align
);

  localparam int XW = pfpu_pkg::EXP_EXT_W;
  localparam int FW = pfpu_pkg::FRACT_EXT_W;

  // leading zeros below the carry bit
  function automatic logic [4:0] lead_zeros(input logic [FW-2:0] v);
    logic [4:0] n;
    n = 5'd0;
    for (int i = 0; i < FW-1; i++) begin
      if (v[i]) n = 5'(FW-2-i);  // highest set bit wins
    end
    return n;
  endfunction

  logic          is_sub;
  logic          is_arith;
  logic          sb_eff;      // b sign after op
  logic          a_ge;        // |a| >= |b|
  logic          big_sign;
  logic          small_sign;
  logic          sub_eff;     // magnitudes get subtracted
  logic [XW-1:0] big_exp;
  logic [XW-1:0] exp_diff;
  logic [4:0]    sh;
  logic [FW-1:0] big_fr;
  logic [FW-1:0] small_fr;
  logic [FW-1:0] small_sh;
  logic [FW-1:0] lost_mask;
  logic [FW-1:0] sum;
  logic          any_snan;
  logic          any_nan;
  logic          inf_sub;     // inf - inf

  logic          s1_valid;
  logic          s1_sign;
  logic [XW-1:0] s1_exp;
  logic [FW-1:0] s1_fract;
  logic          s1_sub;
  logic          s1_inv;
  logic          s1_inf;
  logic          s1_nan;

  logic [4:0]    lz;
  logic [FW-1:0] norm_fr;
  logic [XW-1:0] norm_exp;
  logic          norm_zero;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 align and add
  ////////////////////////////////////////////////////////////////////////////

  assign is_sub   = (op_i == pfpu_pkg::OP_SUB);
  assign is_arith = is_sub | (op_i == pfpu_pkg::OP_ADD);
  assign sb_eff   = b_i.sign ^ is_sub;
  assign a_ge     = {a_i.exp, a_i.fract24} >= {b_i.exp, b_i.fract24};

  always_comb begin
    if (a_ge) begin
      big_sign   = a_i.sign;
      small_sign = sb_eff;
      big_exp    = a_i.exp;
      exp_diff   = a_i.exp - b_i.exp;
      big_fr     = {1'b0, a_i.fract24, 3'b000};
      small_fr   = {1'b0, b_i.fract24, 3'b000};
    end else begin
      big_sign   = sb_eff;
      small_sign = a_i.sign;
      big_exp    = b_i.exp;
      exp_diff   = b_i.exp - a_i.exp;
      big_fr     = {1'b0, b_i.fract24, 3'b000};
      small_fr   = {1'b0, a_i.fract24, 3'b000};
    end
    sh        = (exp_diff >= XW'(FW)) ? 5'(FW) : exp_diff[4:0];  // clamp
    lost_mask = ~({FW{1'b1}} << sh);
    small_sh  = small_fr >> sh;
    small_sh[0] = small_sh[0] | (|(small_fr & lost_mask));  // sticky
    sub_eff   = big_sign ^ small_sign;
    sum       = sub_eff ? big_fr - small_sh : big_fr + small_sh;  // never negative
  end

  // special operands
  assign any_snan = a_i.snan | b_i.snan;
  assign any_nan  = any_snan | a_i.qnan | b_i.qnan;
  assign inf_sub  = a_i.inf & b_i.inf & (a_i.sign ^ sb_eff);

  ////////////////////////////////////////////////////////////////////////////
  // stage 2 normalize
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    lz        = lead_zeros(s1_fract[FW-2:0]);
    norm_zero = ~|s1_fract;
    if (s1_fract[FW-1]) begin
      // carry out, one right with sticky
      norm_fr  = {1'b0, s1_fract[FW-1:2], s1_fract[1] | s1_fract[0]};
      norm_exp = s1_exp + 1'b1;
    end else begin
      norm_fr  = s1_fract << lz;
      norm_exp = s1_exp - XW'(lz);  // can wrap negative, rounder flushes
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid    <= 1'b0;
      align.valid <= 1'b0;
    end else if (flush_i) begin
      s1_valid    <= 1'b0;
      align.valid <= 1'b0;
    end else if (adv_i) begin
      s1_valid    <= start_i & is_arith;
      align.valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_sign  <= big_sign;
      s1_exp   <= big_exp;
      s1_fract <= sum;
      s1_sub   <= sub_eff;
      s1_inv   <= inf_sub | any_snan;
      s1_nan   <= inf_sub | any_nan;
      s1_inf   <= (a_i.inf | b_i.inf) & ~(inf_sub | any_nan);
      // stage 2
      if (s1_nan) begin
        align.sign  <= pfpu_pkg::QNAN_CANON[pfpu_pkg::FP_W-1];
        align.exp   <= XW'(pfpu_pkg::QNAN_CANON[pfpu_pkg::FP_W-2:pfpu_pkg::FRAC_W]);
        align.fract <= {2'b01, pfpu_pkg::QNAN_CANON[pfpu_pkg::FRAC_W-1:0], 3'b000};
      end else begin
        align.sign  <= (norm_zero & s1_sub) ? 1'b0 : s1_sign;  // x - x = +0
        align.exp   <= norm_exp;
        align.fract <= norm_fr;
      end
      align.inv  <= s1_inv;
      align.inf  <= s1_inf;
      align.nan  <= s1_nan;
      align.zero <= norm_zero;
    end
  end

endmodule

// File: logic/pfpu_fcmp.sv
module pfpu_fcmp (
  input  logic                clk,
  input  logic                rst,
  input  logic                flush_i,
  input  logic                adv_i,
  input  logic                start_i,
  input  pfpu_pkg::fpu_op_t   op_i,
  input  pfpu_pkg::fp_class_t a_i,
  input  pfpu_pkg::fp_class_t b_i,
  output logic                cmp_valid_o,
  output logic                cmp_flag_o,
  output logic                cmp_inv_o
);

  logic              is_cmp;
  logic              s1_valid;
  pfpu_pkg::fpu_op_t s1_op;
  logic              s1_gt;    // |a| > |b|
  logic              s1_eq;    // |a| == |b|
  logic              s1_sa;
  logic              s1_sb;
  logic              s1_zero;  // both operands zero
  logic              s1_nan;   // unordered
  logic              s1_snan;
  logic              eq;
  logic              lt;
  logic              res;

  assign is_cmp = (op_i == pfpu_pkg::OP_CMP_EQ) | (op_i == pfpu_pkg::OP_CMP_LT)
                | (op_i == pfpu_pkg::OP_CMP_LE);

  ////////////////////////////////////////////////////////////////////////////
  // valid chain
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid    <= 1'b0;
      cmp_valid_o <= 1'b0;
    end else if (flush_i) begin
      s1_valid    <= 1'b0;
      cmp_valid_o <= 1'b0;
    end else if (adv_i) begin
      s1_valid    <= start_i & is_cmp;  // accepted compare
      cmp_valid_o <= s1_valid;
    end
  end

  // stage 2 sign resolution
  always_comb begin
    eq = s1_zero | ((s1_sa == s1_sb) & s1_eq);  // +0 == -0
    if (s1_zero)
      lt = 1'b0;
    else if (s1_sa != s1_sb)
      lt = s1_sa;                 // negative one is smaller
    else if (s1_sa)
      lt = s1_gt;                 // both negative, larger magnitude is less
    else
      lt = ~s1_gt & ~s1_eq;
    case (s1_op)
      pfpu_pkg::OP_CMP_EQ: res = eq;
      pfpu_pkg::OP_CMP_LT: res = lt;
      default:             res = lt | eq;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 1 magnitude, stage 2 flag
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_op      <= op_i;
      s1_gt      <= {a_i.exp, a_i.fract24} > {b_i.exp, b_i.fract24};
      s1_eq      <= {a_i.exp, a_i.fract24} == {b_i.exp, b_i.fract24};
      s1_sa      <= a_i.sign;
      s1_sb      <= b_i.sign;
      s1_zero    <= a_i.zero & b_i.zero;
      s1_nan     <= a_i.snan | a_i.qnan | b_i.snan | b_i.qnan;
      s1_snan    <= a_i.snan | b_i.snan;
      cmp_flag_o <= s1_nan ? 1'b0 : res;  // unordered never true
      // eq traps on snan only, lt/le on any nan
      cmp_inv_o  <= (s1_op == pfpu_pkg::OP_CMP_EQ) ? s1_snan : s1_nan;
    end
  end

endmodule

// File: logic/fp_operand_unpack.sv
module fp_operand_unpack (
  input  logic [pfpu_pkg::FP_W-1:0] opa_i,
  output pfpu_pkg::fp_class_t       class_o
);

  logic                          sign;
  logic [pfpu_pkg::EXP_W-1:0]    exp;
  logic [pfpu_pkg::FRAC_W-1:0]   frac;
  logic                          exp_ff;  // exponent all ones
  logic                          exp_00;  // exponent all zeros

  // field split
  assign sign   = opa_i[pfpu_pkg::FP_W-1];
  assign exp    = opa_i[pfpu_pkg::FP_W-2 -: pfpu_pkg::EXP_W];
  assign frac   = opa_i[pfpu_pkg::FRAC_W-1:0];
  assign exp_ff = &exp;
  assign exp_00 = ~|exp;

  always_comb begin
    class_o.sign    = sign;
    class_o.exp     = {{(pfpu_pkg::EXP_EXT_W-pfpu_pkg::EXP_W){1'b0}}, exp};
    // denormal fraction dropped, operand becomes signed zero
    class_o.fract24 = exp_00 ? '0 : {1'b1, frac};
    class_o.inf     = exp_ff & ~|frac;
    class_o.zero    = exp_00;
    // quiet bit clear, payload non zero
    class_o.snan    = exp_ff & ~frac[pfpu_pkg::FRAC_W-1]
                    & |frac[pfpu_pkg::FRAC_W-2:0];
    class_o.qnan    = exp_ff & frac[pfpu_pkg::FRAC_W-1];
  end

endmodule

// File: logic/pfpu_align_if.sv
// add/sub stage 2 -> rounder
interface pfpu_align_if ();

  logic                               valid;
  logic                               sign;
  logic [pfpu_pkg::EXP_EXT_W-1:0]     exp;    // may go negative on unf
  logic [pfpu_pkg::FRACT_EXT_W-1:0]   fract;  // hidden at bit 26, g/r/s low
  logic                               inv;    // invalid operation
  logic                               inf;    // result is infinity
  logic                               nan;    // result is nan
  logic                               zero;   // exact zero

  // producer side
  modport src (
    output valid, sign, exp, fract, inv, inf, nan, zero
  );

  // rounder side
  modport dst (
    input valid, sign, exp, fract, inv, inf, nan, zero
  );

endinterface

// File: logic/pfpu_pkg.sv
package pfpu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // field widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int FP_W        = 32;  // operand word
  localparam int EXP_W       = 8;   // ieee single exponent
  localparam int FRAC_W      = 23;  // stored fraction
  localparam int EXP_EXT_W   = 10;  // room for ovf/unf inside the pipe
  localparam int FRACT_EXT_W = 28;  // carry, hidden, 23 fract, g/r/s

  ////////////////////////////////////////////////////////////////////////////
  // opcodes, bit 2 marks a compare
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_ADD    = 3'b000,
    OP_SUB    = 3'b001,
    OP_CMP_EQ = 3'b100,
    OP_CMP_LT = 3'b101,
    OP_CMP_LE = 3'b110
  } fpu_op_t;

  // one unpacked operand
  typedef struct packed {
    logic                 sign;
    logic [EXP_EXT_W-1:0] exp;      // biased, zero extended
    logic [FRAC_W:0]      fract24;  // hidden bit restored
    logic                 inf;
    logic                 zero;     // denormals count as zero
    logic                 snan;
    logic                 qnan;
  } fp_class_t;

  ////////////////////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [FP_W-1:0] QNAN_CANON = 32'h7FC0_0000;

  // fpcsr bit positions
  localparam int FLAG_INV = 2;
  localparam int FLAG_OVF = 1;
  localparam int FLAG_INX = 0;

endpackage
